// ==== verilog/obi_pkg.sv ====
`default_nettype none

// Shared definitions for the observed data bus
package obi_pkg;

  ////////////////////
  // Depth
  ////////////////////

  // The core allows at most two data transfers in flight
  localparam int unsigned MAX_OUTSTANDING = 2;

  ////////////////////
  // Types
  ////////////////////

  // Outstanding transfer count, holds 0 to MAX_OUTSTANDING
  typedef logic [1:0] outst_cnt_t;

  // One write-direction bit per outstanding slot
  // Slot 0 always holds the newest transfer
  typedef logic [1:0] dir_hist_t;

  // Count value at which the bus is full
  localparam outst_cnt_t OUTST_FULL = outst_cnt_t'(MAX_OUTSTANDING);

endpackage

`default_nettype wire

// ==== verilog/check_pkg.sv ====
`default_nettype none

// Violation kinds and checker types of the controller monitor
package check_pkg;

  ////////////////////
  // Violation kinds
  ////////////////////

  // Numbering matters, the log reports the lowest kind first
  typedef enum logic [2:0] {
    VIO_NONE               = 3'd0,
    VIO_OVERFLOW           = 3'd1,
    VIO_NMI_TYPE           = 3'd2,
    VIO_NMI_PENDING        = 3'd3,
    VIO_NMI_LATE           = 3'd4,
    VIO_FENCEI_NO_INSTR    = 3'd5,
    VIO_FENCEI_EARLY_CLEAR = 3'd6,
    VIO_FENCEI_STUCK       = 3'd7
  } vio_e;

  localparam int unsigned NUM_VIO = 7;

  // Bit k-1 carries kind k
  typedef logic [NUM_VIO-1:0] vio_vec_t;

  ////////////////////
  // Counters
  ////////////////////

  typedef logic [1:0] retire_cnt_t;
  typedef logic [7:0] vio_cnt_t;

  // Retire counter saturates here, also the limit when nothing retired with the error
  localparam retire_cnt_t RETIRE_CNT_MAX = 2'd3;
  // Limit when an instruction retired in the error cycle itself
  localparam retire_cnt_t RETIRE_LIMIT_RETIRED = 2'd2;
  localparam vio_cnt_t VIO_CNT_MAX = 8'hff;

  // fence.i handshake tracking
  typedef enum logic [1:0] {
    FI_IDLE = 2'd0,
    FI_REQ  = 2'd1,
    FI_DONE = 2'd2
  } fencei_state_e;

  // One-hot vector for a single violation kind
  function automatic vio_vec_t vio_bit(vio_e kind);
    vio_vec_t v;
    v = '0;
    if (kind != VIO_NONE) begin
      v[int'(kind) - 1] = 1'b1;
    end
    return v;
  endfunction

endpackage

`default_nettype wire

// ==== verilog/obi_mon_if.sv ====
`default_nettype none

// Observed data-bus signals of the core
interface obi_mon_if;

  // Address phase
  logic req;
  logic gnt;
  logic we;
  // Response phase, err qualifies an rvalid cycle
  logic rvalid;
  logic err;

  // Monitor side, observes only
  modport mon (
    input req, gnt, we, rvalid, err
  );

  // Side that feeds the bus values in from the top-level ports
  modport drv (
    output req, gnt, we, rvalid, err
  );

endinterface

`default_nettype wire

// ==== verilog/obi_tracker.sv ====
`default_nettype none

// Follows outstanding data-bus transfers and their direction
module obi_tracker
  import obi_pkg::*;
  import check_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_n,
  obi_mon_if.mon     bus,
  output logic       err_resp_o,
  output logic       err_is_write_o,
  output vio_vec_t   vio_o
);

  outst_cnt_t outst_cnt_q;
  dir_hist_t  dir_hist_q;
  vio_vec_t   vio_q;
  logic       accept;
  logic       overflow;

  // A transfer is accepted when req and gnt meet
  assign accept = bus.req && bus.gnt;

  // A third acceptance with two in flight and no response freeing a slot
  assign overflow = accept && !bus.rvalid && (outst_cnt_q == OUTST_FULL);

  ////////////////////
  // Outstanding count
  ////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      outst_cnt_q <= '0;
      dir_hist_q  <= '0;
    end else begin
      if (accept && !bus.rvalid) begin
        // Count stays at full on overflow
        if (outst_cnt_q != OUTST_FULL) begin
          outst_cnt_q <= outst_cnt_q + 2'd1;
        end
      end else if (!accept && bus.rvalid) begin
        if (outst_cnt_q != '0) begin
          outst_cnt_q <= outst_cnt_q - 2'd1;
        end
      end

      // Newest direction always enters slot 0
      if (accept) begin
        if (bus.rvalid && (outst_cnt_q != OUTST_FULL)) begin
          // The only older transfer leaves as the new one enters
          dir_hist_q[0] <= bus.we;
        end else begin
          dir_hist_q[1] <= dir_hist_q[0];
          dir_hist_q[0] <= bus.we;
        end
      end
    end
  end

  ////////////////////
  // Error response
  ////////////////////

  // Responses come in order, so the response belongs to the oldest transfer
  assign err_resp_o     = bus.rvalid && bus.err;
  assign err_is_write_o = (outst_cnt_q == OUTST_FULL) ? dir_hist_q[1] : dir_hist_q[0];

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      vio_q <= '0;
    end else begin
      vio_q <= overflow ? vio_bit(VIO_OVERFLOW) : '0;
    end
  end

  assign vio_o = vio_q;

  // A response needs a transfer in flight
  a_no_resp_when_idle :
    assert property (@(posedge clk) disable iff (!rst_n)
                     bus.rvalid |-> (outst_cnt_q != '0))
      else $error("obi_tracker: rvalid with no outstanding transfer");

endmodule

`default_nettype wire

// ==== verilog/nmi_retire_check.sv ====
`default_nettype none

// Bus-error NMI rules: latched type, pending state and retire limit
module nmi_retire_check
  import check_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic err_resp_i,
  input  wire logic err_is_write_i,
  input  wire logic wb_valid_i,
  input  wire logic debug_mode_i,
  input  wire logic dcsr_step_i,
  input  wire logic dcsr_stepie_i,
  input  wire logic nmi_pending_i,
  input  wire logic nmi_is_store_i,
  input  wire logic nmi_taken_i,
  output vio_vec_t  vio_o
);

  logic        err_latched_q;
  logic        err_is_write_q;
  logic        retire_at_error_q;
  logic        compare_q;
  retire_cnt_t retire_cnt_q;
  retire_cnt_t retire_limit;
  logic        retire_counts;
  logic        retire_hit;
  vio_vec_t    vio_d;
  vio_vec_t    vio_q;

  ////////////////////
  // Error latch
  ////////////////////

  // Only the first error is kept until the NMI handler is entered
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      err_latched_q     <= 1'b0;
      err_is_write_q    <= 1'b0;
      retire_at_error_q <= 1'b0;
      compare_q         <= 1'b0;
    end else begin
      compare_q <= 1'b0;
      if (err_resp_i && !err_latched_q) begin
        err_latched_q     <= 1'b1;
        err_is_write_q    <= err_is_write_i;
        retire_at_error_q <= wb_valid_i;
        // The core must show the NMI status in the next cycle
        compare_q         <= 1'b1;
      end else if (nmi_taken_i) begin
        err_latched_q <= 1'b0;
      end
    end
  end

  ////////////////////
  // Retire counter
  ////////////////////

  // Retires in debug mode or in a step without interrupts are not counted
  assign retire_counts = err_latched_q && wb_valid_i && !debug_mode_i &&
                         !(dcsr_step_i && !dcsr_stepie_i);

  // One less retire is allowed when an instruction retired with the error
  assign retire_limit = retire_at_error_q ? RETIRE_LIMIT_RETIRED : RETIRE_CNT_MAX;

  // Fires once, on the retire that takes the counter to its limit
  assign retire_hit = retire_counts && (retire_cnt_q != RETIRE_CNT_MAX) &&
                      (retire_cnt_t'(retire_cnt_q + 2'd1) == retire_limit);

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      retire_cnt_q <= '0;
    end else if (!err_latched_q || nmi_taken_i) begin
      retire_cnt_q <= '0;
    end else if (retire_counts && (retire_cnt_q != RETIRE_CNT_MAX)) begin
      retire_cnt_q <= retire_cnt_q + 2'd1;
    end
  end

  ////////////////////
  // Violations
  ////////////////////

  always_comb begin
    vio_d = '0;
    if (compare_q && (nmi_is_store_i != err_is_write_q)) begin
      vio_d |= vio_bit(VIO_NMI_TYPE);
    end
    if (compare_q && !nmi_pending_i) begin
      vio_d |= vio_bit(VIO_NMI_PENDING);
    end
    if (retire_hit) begin
      vio_d |= vio_bit(VIO_NMI_LATE);
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      vio_q <= '0;
    end else begin
      vio_q <= vio_d;
    end
  end

  assign vio_o = vio_q;

  // Taking the NMI releases the latch and restarts the retire count together
  a_nmi_clears_latch :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (err_latched_q && nmi_taken_i) |=> (!err_latched_q && (retire_cnt_q == '0)))
      else $error("nmi_retire_check: error latch held across nmi_taken");

endmodule

`default_nettype wire

// ==== verilog/fencei_check.sv ====
`default_nettype none

// fence.i flush request and acknowledge rules
module fencei_check
  import check_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic fencei_in_wb_i,
  input  wire logic fencei_req_i,
  input  wire logic fencei_ack_i,
  output vio_vec_t  vio_o
);

  fencei_state_e fi_state_q;
  fencei_state_e fi_state_d;
  vio_vec_t      vio_d;
  vio_vec_t      vio_q;

  ////////////////////
  // Handshake FSM
  ////////////////////

  always_comb begin
    fi_state_d = fi_state_q;
    case (fi_state_q)
      FI_IDLE: begin
        if (fencei_req_i) begin
          fi_state_d = fencei_ack_i ? FI_DONE : FI_REQ;
        end
      end
      FI_REQ: begin
        if (!fencei_req_i) begin
          fi_state_d = FI_IDLE;
        end else if (fencei_ack_i) begin
          fi_state_d = FI_DONE;
        end
      end
      // The request must be gone one cycle after the handshake
      FI_DONE: fi_state_d = FI_IDLE;
      default: fi_state_d = FI_IDLE;
    endcase
  end

  always_comb begin
    vio_d = '0;
    if (fencei_req_i && !fencei_in_wb_i) begin
      vio_d |= vio_bit(VIO_FENCEI_NO_INSTR);
    end
    // In FI_REQ the last cycle had a request without an acknowledge
    if ((fi_state_q == FI_REQ) && !fencei_req_i) begin
      vio_d |= vio_bit(VIO_FENCEI_EARLY_CLEAR);
    end
    if ((fi_state_q == FI_DONE) && fencei_req_i) begin
      vio_d |= vio_bit(VIO_FENCEI_STUCK);
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      fi_state_q <= FI_IDLE;
      vio_q      <= '0;
    end else begin
      fi_state_q <= fi_state_d;
      vio_q      <= vio_d;
    end
  end

  assign vio_o = vio_q;

  a_fi_state_legal :
    assert property (@(posedge clk) disable iff (!rst_n)
                     fi_state_q inside {FI_IDLE, FI_REQ, FI_DONE})
      else $error("fencei_check: illegal state encoding");

endmodule

`default_nettype wire

// ==== verilog/violation_log.sv ====
`default_nettype none

// Sticky violation flags, first violation and event count
module violation_log
  import check_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst_n,
  input  wire vio_vec_t vio_i,
  output vio_vec_t      vio_flags_o,
  output vio_e          vio_first_o,
  output vio_cnt_t      vio_count_o
);

  vio_vec_t vio_flags_q;
  vio_e     vio_first_q;
  vio_cnt_t vio_count_q;
  vio_e     lowest_kind;
  logic     any_vio;

  assign any_vio = |vio_i;

  // Lowest set bit wins, so scan downwards and let the last hit stand
  always_comb begin
    lowest_kind = VIO_NONE;
    for (int k = NUM_VIO - 1; k >= 0; k--) begin
      if (vio_i[k]) begin
        lowest_kind = vio_e'(k + 1);
      end
    end
  end

  ////////////////////
  // Log registers
  ////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      vio_flags_q <= '0;
      vio_first_q <= VIO_NONE;
      vio_count_q <= '0;
    end else begin
      vio_flags_q <= vio_flags_q | vio_i;
      // Only the first cycle with any pulse decides
      if ((vio_first_q == VIO_NONE) && any_vio) begin
        vio_first_q <= lowest_kind;
      end
      // One count per pulse cycle, held at the top
      if (any_vio && (vio_count_q != VIO_CNT_MAX)) begin
        vio_count_q <= vio_count_q + 8'd1;
      end
    end
  end

  assign vio_flags_o = vio_flags_q;
  assign vio_first_o = vio_first_q;
  assign vio_count_o = vio_count_q;

  a_first_is_stable :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (vio_first_q != VIO_NONE) |=> $stable(vio_first_q))
      else $error("violation_log: first violation changed");

endmodule

`default_nettype wire

// ==== verilog/ctrl_monitor_top.sv ====
`default_nettype none

// Run-time monitor for the core controller
module ctrl_monitor_top
  import check_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n,
  // Data bus
  input  wire logic data_req_i,
  input  wire logic data_gnt_i,
  input  wire logic data_we_i,
  input  wire logic data_rvalid_i,
  input  wire logic data_err_i,
  // Retire, debug and NMI status
  input  wire logic wb_valid_i,
  input  wire logic debug_mode_i,
  input  wire logic dcsr_step_i,
  input  wire logic dcsr_stepie_i,
  input  wire logic nmi_pending_i,
  input  wire logic nmi_is_store_i,
  input  wire logic nmi_taken_i,
  // fence.i flush handshake
  input  wire logic fencei_in_wb_i,
  input  wire logic fencei_req_i,
  input  wire logic fencei_ack_i,
  output vio_vec_t  vio_flags_o,
  output vio_e      vio_first_o,
  output vio_cnt_t  vio_count_o
);

  logic     err_resp;
  logic     err_is_write;
  vio_vec_t trk_vio;
  vio_vec_t nmi_vio;
  vio_vec_t fi_vio;
  vio_vec_t all_vio;

  obi_mon_if bus_if ();

  // Plain ports fill the bus bundle in the driver direction
  assign bus_if.req    = data_req_i;
  assign bus_if.gnt    = data_gnt_i;
  assign bus_if.we     = data_we_i;
  assign bus_if.rvalid = data_rvalid_i;
  assign bus_if.err    = data_err_i;

  ////////////////////
  // Input side
  ////////////////////

  obi_tracker u_tracker (
    .clk            (clk),
    .rst_n          (rst_n),
    .bus            (bus_if.mon),
    .err_resp_o     (err_resp),
    .err_is_write_o (err_is_write),
    .vio_o          (trk_vio)
  );

  ////////////////////
  // Rule checkers
  ////////////////////

  nmi_retire_check u_nmi_check (
    .clk            (clk),
    .rst_n          (rst_n),
    .err_resp_i     (err_resp),
    .err_is_write_i (err_is_write),
    .wb_valid_i     (wb_valid_i),
    .debug_mode_i   (debug_mode_i),
    .dcsr_step_i    (dcsr_step_i),
    .dcsr_stepie_i  (dcsr_stepie_i),
    .nmi_pending_i  (nmi_pending_i),
    .nmi_is_store_i (nmi_is_store_i),
    .nmi_taken_i    (nmi_taken_i),
    .vio_o          (nmi_vio)
  );

  fencei_check u_fencei_check (
    .clk            (clk),
    .rst_n          (rst_n),
    .fencei_in_wb_i (fencei_in_wb_i),
    .fencei_req_i   (fencei_req_i),
    .fencei_ack_i   (fencei_ack_i),
    .vio_o          (fi_vio)
  );

  // Each kind has its own bit, so the pulses never collide
  assign all_vio = trk_vio | nmi_vio | fi_vio;

  ////////////////////
  // Output side
  ////////////////////

  violation_log u_log (
    .clk         (clk),
    .rst_n       (rst_n),
    .vio_i       (all_vio),
    .vio_flags_o (vio_flags_o),
    .vio_first_o (vio_first_o),
    .vio_count_o (vio_count_o)
  );

endmodule

`default_nettype wire

// ==== test/tb_ctrl_monitor.sv ====
`default_nettype none

module tb_ctrl_monitor
  import obi_pkg::*;
  import check_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned CLK_PERIOD    = 100;
  localparam int unsigned RESET_CYCLES  = 16;
  localparam int unsigned NUM_ROWS      = 45;
  localparam int unsigned RAND_CYCLES   = 200;
  // Room for the reset pulses between scenarios and the drain cycles
  localparam int unsigned MARGIN_CYCLES = 60;
  localparam int unsigned TIMEOUT_CYCLES = RESET_CYCLES + NUM_ROWS + RAND_CYCLES + MARGIN_CYCLES;

  // One table row is one clock cycle of stimulus plus the outputs expected before it is driven
  typedef struct packed {
    logic       clr;    // Pulse reset before this row
    logic [4:0] bus;    // req gnt we rvalid err
    logic [6:0] core;   // wb_valid debug_mode step stepie nmi_pending nmi_is_store nmi_taken
    logic [2:0] fi;     // fencei_in_wb fencei_req fencei_ack
    vio_vec_t   flags;
    logic [2:0] first;
    vio_cnt_t   count;
  } row_t;

  logic     clk;
  logic     rst_n;
  logic     data_req;
  logic     data_gnt;
  logic     data_we;
  logic     data_rvalid;
  logic     data_err;
  logic     wb_valid;
  logic     debug_mode;
  logic     dcsr_step;
  logic     dcsr_stepie;
  logic     nmi_pending;
  logic     nmi_is_store;
  logic     nmi_taken;
  logic     fencei_in_wb;
  logic     fencei_req;
  logic     fencei_ack;
  vio_vec_t vio_flags;
  vio_e     vio_first;
  vio_cnt_t vio_count;

  int       flag_errors;
  int       first_errors;
  int       count_errors;
  logic [31:0] rng_state;

  ////////////////////
  // Stimulus table
  ////////////////////

  // Expected values in row i show the effect of inputs driven in rows up to i-2,
  // since each offending cycle appears on the log outputs two edges after it is sampled
  row_t rows [NUM_ROWS] = '{
    // Legal traffic with two transfers in flight and then a clean fence.i handshake
    {1'b0, 5'b11100, 7'b0000000, 3'b000, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b11000, 7'b0000000, 3'b000, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b00010, 7'b0000000, 3'b000, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b00010, 7'b0000000, 3'b000, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b00000, 7'b0000000, 3'b110, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b00000, 7'b0000000, 3'b111, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b00000, 7'b0000000, 3'b000, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b00000, 7'b0000000, 3'b000, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b00000, 7'b0000000, 3'b000, 7'h00, 3'd0, 8'd0},
    // Third acceptance with two outstanding
    {1'b1, 5'b11100, 7'b0000000, 3'b000, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b11000, 7'b0000000, 3'b000, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b11000, 7'b0000000, 3'b000, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b00010, 7'b0000000, 3'b000, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b00010, 7'b0000000, 3'b000, 7'h01, 3'd1, 8'd1},
    {1'b0, 5'b00000, 7'b0000000, 3'b000, 7'h01, 3'd1, 8'd1},
    // Write then read where the write errors and the core reports a load NMI
    {1'b1, 5'b11100, 7'b0000000, 3'b000, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b11000, 7'b0000000, 3'b000, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b00011, 7'b0000000, 3'b000, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b00011, 7'b0000100, 3'b000, 7'h00, 3'd0, 8'd0},
    // A relatch on the second error would flag the dropped pending bit here
    {1'b0, 5'b00000, 7'b0000001, 3'b000, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b00000, 7'b0000000, 3'b000, 7'h02, 3'd2, 8'd1},
    {1'b0, 5'b00000, 7'b0000000, 3'b000, 7'h02, 3'd2, 8'd1},
    // Two counted retires are allowed after a read error
    {1'b1, 5'b11000, 7'b0000000, 3'b000, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b00011, 7'b0000000, 3'b000, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b00000, 7'b1000100, 3'b000, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b00000, 7'b1000100, 3'b000, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b00000, 7'b0000101, 3'b000, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b00000, 7'b0000000, 3'b000, 7'h00, 3'd0, 8'd0},
    // After a second read error a debug retire is free and the third counted one is late
    {1'b0, 5'b11000, 7'b0000000, 3'b000, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b00011, 7'b0000000, 3'b000, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b00000, 7'b1100100, 3'b000, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b00000, 7'b1000100, 3'b000, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b00000, 7'b1000100, 3'b000, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b00000, 7'b1000100, 3'b000, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b00000, 7'b0000101, 3'b000, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b00000, 7'b0000000, 3'b000, 7'h08, 3'd4, 8'd1},
    {1'b0, 5'b00000, 7'b0000000, 3'b000, 7'h08, 3'd4, 8'd1},
    // A fence.i request without the instruction, an early drop and then a request held too long
    {1'b1, 5'b00000, 7'b0000000, 3'b010, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b00000, 7'b0000000, 3'b000, 7'h00, 3'd0, 8'd0},
    {1'b0, 5'b00000, 7'b0000000, 3'b110, 7'h10, 3'd5, 8'd1},
    {1'b0, 5'b00000, 7'b0000000, 3'b111, 7'h30, 3'd5, 8'd2},
    {1'b0, 5'b00000, 7'b0000000, 3'b110, 7'h30, 3'd5, 8'd2},
    {1'b0, 5'b00000, 7'b0000000, 3'b000, 7'h30, 3'd5, 8'd2},
    {1'b0, 5'b00000, 7'b0000000, 3'b000, 7'h70, 3'd5, 8'd3},
    {1'b0, 5'b00000, 7'b0000000, 3'b000, 7'h70, 3'd5, 8'd3}
  };

  ctrl_monitor_top uut (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_i     (data_req),
    .data_gnt_i     (data_gnt),
    .data_we_i      (data_we),
    .data_rvalid_i  (data_rvalid),
    .data_err_i     (data_err),
    .wb_valid_i     (wb_valid),
    .debug_mode_i   (debug_mode),
    .dcsr_step_i    (dcsr_step),
    .dcsr_stepie_i  (dcsr_stepie),
    .nmi_pending_i  (nmi_pending),
    .nmi_is_store_i (nmi_is_store),
    .nmi_taken_i    (nmi_taken),
    .fencei_in_wb_i (fencei_in_wb),
    .fencei_req_i   (fencei_req),
    .fencei_ack_i   (fencei_ack),
    .vio_flags_o    (vio_flags),
    .vio_first_o    (vio_first),
    .vio_count_o    (vio_count)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic set_idle();
    {data_req, data_gnt, data_we, data_rvalid, data_err} = 5'b0;
    {wb_valid, debug_mode, dcsr_step, dcsr_stepie} = 4'b0;
    {nmi_pending, nmi_is_store, nmi_taken} = 3'b0;
    {fencei_in_wb, fencei_req, fencei_ack} = 3'b0;
  endtask

  task automatic drive_row(input row_t r);
    {data_req, data_gnt, data_we, data_rvalid, data_err} = r.bus;
    {wb_valid, debug_mode, dcsr_step, dcsr_stepie, nmi_pending, nmi_is_store, nmi_taken} = r.core;
    {fencei_in_wb, fencei_req, fencei_ack} = r.fi;
  endtask

  // Reset is asynchronous and its release lands mid-cycle away from the clock edge
  task automatic pulse_reset();
    rst_n = 1'b0;
    set_idle();
    repeat (2) @(posedge clk);
    #5;
    rst_n = 1'b1;
  endtask

  task automatic check_outputs(input string phase, input int idx, input vio_vec_t exp_flags,
                               input logic [2:0] exp_first, input vio_cnt_t exp_count);
    if (vio_flags !== exp_flags) begin
      $display("MISMATCH %s %0d: vio_flags_o got 0x%h, expected 0x%h",
               phase, idx, vio_flags, exp_flags);
      flag_errors++;
    end
    if (vio_first !== exp_first) begin
      $display("MISMATCH %s %0d: vio_first_o got 0x%h, expected 0x%h",
               phase, idx, vio_first, exp_first);
      first_errors++;
    end
    if (vio_count !== exp_count) begin
      $display("MISMATCH %s %0d: vio_count_o got 0x%h, expected 0x%h",
               phase, idx, vio_count, exp_count);
      count_errors++;
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin : main_seq
    int outst;
    logic resp;
    logic allowed;
    logic acc;
    flag_errors  = 0;
    first_errors = 0;
    count_errors = 0;
    rng_state    = 32'd32;
    rst_n        = 1'b0;
    set_idle();
    repeat (RESET_CYCLES) @(posedge clk);
    #5;
    rst_n = 1'b1;

    // Outputs are checked just after the edge and then the row is driven
    for (int i = 0; i < NUM_ROWS; i++) begin
      if (rows[i].clr) begin
        pulse_reset();
      end
      @(posedge clk);
      #5;
      check_outputs("row", i, rows[i].flags, rows[i].first, rows[i].count);
      drive_row(rows[i]);
    end

    // Random legal traffic with no errors and fence.i idle
    pulse_reset();
    outst = 0;
    for (int c = 0; c < RAND_CYCLES; c++) begin
      @(posedge clk);
      #5;
      check_outputs("random cycle", c, 7'h00, 3'd0, 8'd0);
      rng_state = lcg_next(rng_state);
      resp    = (outst != 0) && rng_state[20];
      // A response in the same cycle frees the slot a full bus needs
      allowed = (outst < int'(MAX_OUTSTANDING)) || resp;
      data_req     = rng_state[22];
      data_gnt     = rng_state[23] && allowed;
      data_we      = rng_state[24];
      data_rvalid  = resp;
      data_err     = 1'b0;
      wb_valid     = rng_state[25];
      debug_mode   = rng_state[26];
      dcsr_step    = rng_state[27];
      dcsr_stepie  = rng_state[28];
      fencei_in_wb = rng_state[29];
      acc = data_req && data_gnt;
      if (acc && !resp) begin
        outst++;
      end else if (!acc && resp) begin
        outst--;
      end
    end
    // Let the last random cycles reach the log
    for (int c = 0; c < 2; c++) begin
      @(posedge clk);
      #5;
      check_outputs("drain cycle", c, 7'h00, 3'd0, 8'd0);
      set_idle();
    end

    $display("Errors: vio_flags_o %0d, vio_first_o %0d, vio_count_o %0d",
             flag_errors, first_errors, count_errors);
    if ((flag_errors + first_errors + count_errors) == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Ends a run that stops making progress
  initial begin : watchdog
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== ctrl_monitor.f ====
verilog/obi_pkg.sv
verilog/check_pkg.sv
verilog/obi_mon_if.sv
verilog/obi_tracker.sv
verilog/nmi_retire_check.sv
verilog/fencei_check.sv
verilog/violation_log.sv
verilog/ctrl_monitor_top.sv
test/tb_ctrl_monitor.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run the testbench and scan the log for failures
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_ctrl_monitor \
  -f ctrl_monitor.f -o tb_ctrl_monitor \
  && ./obj_dir/tb_ctrl_monitor > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Simulation build or run failed"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log \
  && { echo "FAIL"; exit 1; } \
  || { echo "PASS"; exit 0; }
